// File: mac_pkg.sv
package mac_pkg;

    // ======================================================================
    // Sequencer state encoding
    // ======================================================================

    // IDLE waits for start, CONV_RUN walks the row wavefront,
    // TRANS_MUL is the single diagonal product step,
    // TRANS_OUT drains the diagonal one word per cycle
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        CONV_RUN  = 2'd1,
        TRANS_MUL = 2'd2,
        TRANS_OUT = 2'd3
    } seq_state_t;

    // ======================================================================
    // Default sizing
    // ======================================================================

    // Data word width in bits
    localparam int DW_DEFAULT  = 16;

    // Array is DIM_DEFAULT by DIM_DEFAULT PEs
    localparam int DIM_DEFAULT = 4;

    // Bits needed to index dim entries, never below one
    function automatic int idx_w(input int dim);
        if (dim < 2) begin
            return 1;
        end
        return $clog2(dim);
    endfunction

endpackage

// File: pe_ctrl_if.sv
`timescale 1ns/100ps

interface pe_ctrl_if #(
    parameter int Dimension = mac_pkg::DIM_DEFAULT
);

    // Width of the diagonal select
    localparam int SEL_W = mac_pkg::idx_w(Dimension);

    // ======================================================================
    // Array controls
    // ======================================================================

    // One bit per row, capture weight and ifmap
    logic [Dimension-1:0] row_load;
    // One bit per row, psum register update
    logic [Dimension-1:0] row_psum_en;
    // Zero every psum in the grid
    logic                 clear_psum;
    // Diagonal-only operation for transposed convolution
    logic                 diag_mode;

    // ======================================================================
    // Collect stage controls
    // ======================================================================

    // Diagonal PE index to read out
    logic [SEL_W-1:0]     diag_sel;
    // Register the selected word this cycle
    logic                 diag_out_en;

    // Sequencer side drives everything
    modport ctrl (
        output row_load, row_psum_en, clear_psum, diag_mode, diag_sel, diag_out_en
    );

    modport array (input row_load, row_psum_en, clear_psum, diag_mode);

    modport collect (input diag_sel, diag_out_en);

endinterface

// File: mac_pe.sv
`timescale 1ns/100ps

module mac_pe #(
    parameter int DW = mac_pkg::DW_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 load,
    input  logic                 psum_en,
    input  logic                 clear,
    input  logic signed [DW-1:0] weight_d,
    input  logic signed [DW-1:0] ifmap_d,
    input  logic signed [DW-1:0] psum_in,
    output logic signed [DW-1:0] psum_out
);

    logic signed [DW-1:0]   weight_q;
    logic signed [DW-1:0]   ifmap_q;
    logic signed [DW-1:0]   psum_q;
    // Low word of the product
    logic signed [DW-1:0]   product;

    // Operand capture
    always_ff @(posedge clk) begin
        if (load) begin
            weight_q <= weight_d;
            ifmap_q  <= ifmap_d;
        end
    end

    assign product = weight_q * ifmap_q;

    // ======================================================================
    // Partial sum, wraps modulo 2**DW
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_q <= '0;
        end else if (clear) begin
            // Clear wins over accumulate
            psum_q <= '0;
        end else if (psum_en) begin
            psum_q <= psum_in + product;
        end
    end

    assign psum_out = psum_q;

endmodule

// File: pe_array.sv
`timescale 1ns/100ps

module pe_array #(
    parameter int DW        = mac_pkg::DW_DEFAULT,
    parameter int Dimension = mac_pkg::DIM_DEFAULT
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [Dimension-1:0][DW-1:0]  weight_in,
    input  logic [Dimension-1:0][DW-1:0]  ifmap_in,
    pe_ctrl_if.array                      ctrl,
    output logic [Dimension-1:0][DW-1:0]  conv_result,
    output logic [Dimension-1:0][DW-1:0]  diag_out
);

    // Psum register of every PE, indexed [row][col]
    logic signed [DW-1:0] psum [Dimension][Dimension];

    // ======================================================================
    // PE grid
    // ======================================================================

    for (genvar r = 0; r < Dimension; r++) begin : g_row
        for (genvar c = 0; c < Dimension; c++) begin : g_col
            // Rotated ifmap word for the correlation
            localparam int  SRC     = (r + c) % Dimension;
            localparam bit  IS_DIAG = (r == c);

            logic                 pe_load;
            logic                 pe_psum_en;
            logic signed [DW-1:0] pe_ifmap;
            logic signed [DW-1:0] pe_psum_in;

            // Diagonal mode leaves only the r == c PEs active
            assign pe_load    = ctrl.row_load[r] & (IS_DIAG | ~ctrl.diag_mode);
            assign pe_psum_en = ctrl.row_psum_en[r] & (IS_DIAG | ~ctrl.diag_mode);

            if (IS_DIAG && r != 0) begin : g_diag_ifmap
                // Transposed mode wants x[k] on PE (k,k), not the rotated word
                assign pe_ifmap = ctrl.diag_mode ? ifmap_in[c] : ifmap_in[SRC];
            end else begin : g_rot_ifmap
                // PE (0,0) already sees x[0], off-diagonal PEs never load in diag mode
                assign pe_ifmap = ifmap_in[SRC];
            end

            // Psum chains down each column, top row starts from zero
            if (r == 0) begin : g_top
                assign pe_psum_in = '0;
            end else begin : g_chain
                assign pe_psum_in = ctrl.diag_mode ? '0 : psum[r-1][c];
            end

            mac_pe #(
                .DW(DW)
            ) mac_pe_i (
                .clk      (clk),
                .rst_n    (rst_n),
                .load     (pe_load),
                .psum_en  (pe_psum_en),
                .clear    (ctrl.clear_psum),
                .weight_d (weight_in[r]),
                .ifmap_d  (pe_ifmap),
                .psum_in  (pe_psum_in),
                .psum_out (psum[r][c])
            );
        end
    end

    // ======================================================================
    // Result taps
    // ======================================================================

    for (genvar k = 0; k < Dimension; k++) begin : g_tap
        // Bottom row holds the finished correlation words
        assign conv_result[k] = psum[Dimension-1][k];
        assign diag_out[k]    = psum[k][k];
    end

endmodule

// File: array_sequencer.sv
`timescale 1ns/100ps

module array_sequencer #(
    parameter int Dimension = mac_pkg::DIM_DEFAULT
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       conv_mode,
    input  logic       start,
    output logic       busy,
    output logic       conv_valid,
    pe_ctrl_if.ctrl    pe_ctrl
);

    // Counter must reach Dimension for the tail cycle
    localparam int CW = mac_pkg::idx_w(Dimension + 1);
    localparam int SW = mac_pkg::idx_w(Dimension);
    localparam logic [CW-1:0] LAST = CW'(Dimension);

    mac_pkg::seq_state_t state_q;
    mac_pkg::seq_state_t state_d;
    logic [CW-1:0]       cnt_q;
    logic [CW-1:0]       cnt_d;
    // Mode captured at the start edge
    logic                mode_q;

    // ======================================================================
    // State, counter and mode registers
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mac_pkg::IDLE;
            cnt_q   <= '0;
            mode_q  <= 1'b0;
            busy    <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            // High from the start edge until the run returns to IDLE
            busy    <= (state_d != mac_pkg::IDLE);
            if (state_q == mac_pkg::IDLE && start) begin
                mode_q <= conv_mode;
            end
        end
    end

    // ======================================================================
    // Next state
    // ======================================================================

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            mac_pkg::IDLE: begin
                // Start is only looked at here, so a start while busy is dropped
                if (start) begin
                    state_d = conv_mode ? mac_pkg::TRANS_MUL : mac_pkg::CONV_RUN;
                    cnt_d   = '0;
                end
            end
            mac_pkg::TRANS_MUL: begin
                state_d = mac_pkg::TRANS_OUT;
                cnt_d   = '0;
            end
            // CONV_RUN and TRANS_OUT share the count to LAST
            default: begin
                if (cnt_q == LAST) begin
                    state_d = mac_pkg::IDLE;
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
        endcase
    end

    // ======================================================================
    // Control outputs
    // ======================================================================

    always_comb begin
        pe_ctrl.row_load    = '0;
        pe_ctrl.row_psum_en = '0;
        pe_ctrl.clear_psum  = 1'b0;
        pe_ctrl.diag_mode   = mode_q;
        pe_ctrl.diag_sel    = '0;
        pe_ctrl.diag_out_en = 1'b0;
        conv_valid          = 1'b0;
        case (state_q)
            mac_pkg::IDLE: begin
                // Steering follows the live mode input for the load edge
                pe_ctrl.diag_mode = conv_mode;
                if (start) begin
                    pe_ctrl.row_load   = '1;
                    pe_ctrl.clear_psum = 1'b1;
                end
            end
            mac_pkg::CONV_RUN: begin
                // One-hot wavefront, then one cycle of valid result
                if (cnt_q < LAST) begin
                    pe_ctrl.row_psum_en = Dimension'(1) << cnt_q;
                end else begin
                    conv_valid = 1'b1;
                end
            end
            mac_pkg::TRANS_MUL: begin
                // Array gates this down to the diagonal
                pe_ctrl.row_psum_en = '1;
            end
            mac_pkg::TRANS_OUT: begin
                if (cnt_q < LAST) begin
                    pe_ctrl.diag_sel    = cnt_q[SW-1:0];
                    pe_ctrl.diag_out_en = 1'b1;
                end
            end
        endcase
    end

endmodule

// File: transconv_collect.sv
`timescale 1ns/100ps

module transconv_collect #(
    parameter int DW        = mac_pkg::DW_DEFAULT,
    parameter int Dimension = mac_pkg::DIM_DEFAULT
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [Dimension-1:0][DW-1:0]            diag_out,
    pe_ctrl_if.collect                              ctrl,
    output logic signed [DW-1:0]                    result,
    output logic [mac_pkg::idx_w(Dimension)-1:0]    col_id,
    output logic                                    partial_valid
);

    // Diagonal word picked by diag_sel
    logic signed [DW-1:0] sel_word;

    // ======================================================================
    // Select mux
    // ======================================================================

    always_comb begin
        sel_word = '0;
        for (int k = 0; k < Dimension; k++) begin
            if (ctrl.diag_sel == k) begin
                sel_word = diag_out[k];
            end
        end
    end

    // ======================================================================
    // Output register
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result        <= '0;
            col_id        <= '0;
            partial_valid <= 1'b0;
        end else begin
            // Valid follows the enable one cycle later
            partial_valid <= ctrl.diag_out_en;
            if (ctrl.diag_out_en) begin
                result <= sel_word;
                col_id <= ctrl.diag_sel;
            end
        end
    end

endmodule

// File: unified_multiplicator.sv
`timescale 1ns/100ps

module unified_multiplicator #(
    parameter int DW        = mac_pkg::DW_DEFAULT,
    parameter int Dimension = mac_pkg::DIM_DEFAULT
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    // 0 for 1D convolution, 1 for transposed convolution
    input  logic                                    conv_mode,
    input  logic                                    start,
    input  logic [Dimension-1:0][DW-1:0]            weight_in,
    input  logic [Dimension-1:0][DW-1:0]            ifmap_in,
    output logic                                    busy,
    output logic [Dimension-1:0][DW-1:0]            conv_result,
    output logic                                    conv_valid,
    output logic signed [DW-1:0]                    transconv_result,
    output logic [mac_pkg::idx_w(Dimension)-1:0]    transconv_col_id,
    output logic                                    transconv_partial_valid
);

    // Diagonal PE psums into the collect stage
    logic [Dimension-1:0][DW-1:0] diag_out;

    pe_ctrl_if #(
        .Dimension(Dimension)
    ) pe_ctrl_i ();

    // ======================================================================
    // Control, datapath and readout
    // ======================================================================

    array_sequencer #(
        .Dimension(Dimension)
    ) array_sequencer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .conv_mode  (conv_mode),
        .start      (start),
        .busy       (busy),
        .conv_valid (conv_valid),
        .pe_ctrl    (pe_ctrl_i.ctrl)
    );

    pe_array #(
        .DW        (DW),
        .Dimension (Dimension)
    ) pe_array_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_in   (weight_in),
        .ifmap_in    (ifmap_in),
        .ctrl        (pe_ctrl_i.array),
        .conv_result (conv_result),
        .diag_out    (diag_out)
    );

    transconv_collect #(
        .DW        (DW),
        .Dimension (Dimension)
    ) transconv_collect_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .diag_out      (diag_out),
        .ctrl          (pe_ctrl_i.collect),
        .result        (transconv_result),
        .col_id        (transconv_col_id),
        .partial_valid (transconv_partial_valid)
    );

endmodule

// File: tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Reference behavior for the multiplier array
// Expects DW and DIM as localparams of the including module

// 32-bit xorshift step, shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// Circular correlation, word j sums w[i] * x[(i+j) mod DIM]
function automatic logic [DIM-1:0][DW-1:0] correlate(
    input logic [DIM-1:0][DW-1:0] w,
    input logic [DIM-1:0][DW-1:0] x
);
    logic [DIM-1:0][DW-1:0] res;
    longint                 acc;
    for (int j = 0; j < DIM; j++) begin
        acc = 0;
        for (int i = 0; i < DIM; i++) begin
            acc += longint'($signed(w[i])) * longint'($signed(x[(i + j) % DIM]));
        end
        // Keep only the low word, i.e. wrap modulo 2**DW
        res[j] = acc[DW-1:0];
    end
    return res;
endfunction

// Element-wise products for the diagonal
function automatic logic [DIM-1:0][DW-1:0] diag_products(
    input logic [DIM-1:0][DW-1:0] w,
    input logic [DIM-1:0][DW-1:0] x
);
    logic [DIM-1:0][DW-1:0] res;
    longint                 p;
    for (int k = 0; k < DIM; k++) begin
        p      = longint'($signed(w[k])) * longint'($signed(x[k]));
        res[k] = p[DW-1:0];
    end
    return res;
endfunction

`endif

// File: tb_unified_multiplicator.sv
`timescale 1ns/100ps

module tb_unified_multiplicator;

    localparam int DW           = mac_pkg::DW_DEFAULT;
    localparam int DIM          = mac_pkg::DIM_DEFAULT;
    localparam int COL_W        = mac_pkg::idx_w(DIM);
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    // Watchdog budget
    localparam int RUN_COUNT    = 40;
    localparam int RUN_CYCLES   = 12;
    localparam int IDLE_LIMIT   = 20;

    `include "tb_model.svh"

    logic                      clk;
    logic                      rst_n;
    logic                      conv_mode;
    logic                      start;
    logic [DIM-1:0][DW-1:0]    weight_in;
    logic [DIM-1:0][DW-1:0]    ifmap_in;
    logic                      busy;
    logic [DIM-1:0][DW-1:0]    conv_result;
    logic                      conv_valid;
    logic signed [DW-1:0]      transconv_result;
    logic [COL_W-1:0]          transconv_col_id;
    logic                      transconv_partial_valid;

    // Reference run tracking, ref_cyc is n after edge Tn
    logic                      ref_busy;
    int                        ref_cyc;
    logic                      ref_mode;
    logic [DIM-1:0][DW-1:0]    ref_conv;
    logic [DIM-1:0][DW-1:0]    ref_diag;
    logic                      exp_conv_valid;
    logic                      exp_tv;
    logic [COL_W-1:0]          exp_col;
    logic [DW-1:0]             exp_tres;

    int          err_count    = 0;
    int          runs_planned = 0;
    int          runs_started = 0;
    logic [31:0] rng_state    = 32'h68c8_9d3a;

    unified_multiplicator #(
        .DW        (DW),
        .Dimension (DIM)
    ) unified_multiplicator_i (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .conv_mode               (conv_mode),
        .start                   (start),
        .weight_in               (weight_in),
        .ifmap_in                (ifmap_in),
        .busy                    (busy),
        .conv_result             (conv_result),
        .conv_valid              (conv_valid),
        .transconv_result        (transconv_result),
        .transconv_col_id        (transconv_col_id),
        .transconv_partial_valid (transconv_partial_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Reference timeline, follows the start edge rules
    // ======================================================================

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_busy <= 1'b0;
            ref_cyc  <= 0;
            ref_mode <= 1'b0;
        end else if (!ref_busy) begin
            // T0, start only counts while idle
            if (start) begin
                ref_busy     <= 1'b1;
                ref_cyc      <= 0;
                ref_mode     <= conv_mode;
                ref_conv     <= correlate(weight_in, ifmap_in);
                ref_diag     <= diag_products(weight_in, ifmap_in);
                runs_started <= runs_started + 1;
            end
        end else begin
            ref_cyc <= ref_cyc + 1;
            // Mode 0 ends at T(DIM+1), mode 1 at T(DIM+2)
            if (ref_cyc + 1 == (ref_mode ? DIM + 2 : DIM + 1)) begin
                ref_busy <= 1'b0;
            end
        end
    end

    assign exp_conv_valid = ref_busy && !ref_mode && ref_cyc == DIM;
    assign exp_tv   = ref_busy && ref_mode && ref_cyc >= 2 && ref_cyc <= DIM + 1;
    assign exp_col  = COL_W'(ref_cyc - 2);
    assign exp_tres = ref_diag[exp_col];

    // ======================================================================
    // Checks, sampled on the falling edge where outputs are settled
    // ======================================================================

    a_reset_idle: assert property (@(negedge clk)
        !rst_n |-> (!busy && !conv_valid && !transconv_partial_valid))
        else begin
            err_count++;
            $display("busy or a valid output was high during reset");
        end

    a_busy: assert property (@(negedge clk) disable iff (!rst_n) busy == ref_busy)
        else begin
            err_count++;
            $display("CHECK FAILED busy: got %h expected %h", busy, ref_busy);
        end

    a_conv_valid: assert property (@(negedge clk) disable iff (!rst_n)
        conv_valid == exp_conv_valid)
        else begin
            err_count++;
            $display("CHECK FAILED conv_valid: got %h expected %h",
                     conv_valid, exp_conv_valid);
        end

    a_conv_result: assert property (@(negedge clk) disable iff (!rst_n)
        exp_conv_valid |-> conv_result == ref_conv)
        else begin
            err_count++;
            $display("CHECK FAILED conv_result: got %h expected %h", conv_result, ref_conv);
        end

    a_partial_valid: assert property (@(negedge clk) disable iff (!rst_n)
        transconv_partial_valid == exp_tv)
        else begin
            err_count++;
            $display("CHECK FAILED transconv_partial_valid: got %h expected %h",
                     transconv_partial_valid, exp_tv);
        end

    a_col_id: assert property (@(negedge clk) disable iff (!rst_n)
        exp_tv |-> transconv_col_id == exp_col)
        else begin
            err_count++;
            $display("CHECK FAILED transconv_col_id: got %h expected %h",
                     transconv_col_id, exp_col);
        end

    a_trans_result: assert property (@(negedge clk) disable iff (!rst_n)
        exp_tv |-> transconv_result == exp_tres)
        else begin
            err_count++;
            $display("CHECK FAILED transconv_result: got %h expected %h",
                     transconv_result, exp_tres);
        end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    // Mostly random words, sometimes the wrap corners
    function automatic logic [DW-1:0] random_word();
        rng_state = xorshift32(rng_state);
        case (rng_state[31:29])
            3'd0:    return {1'b1, {(DW-1){1'b0}}};
            3'd1:    return {1'b0, {(DW-1){1'b1}}};
            3'd2:    return '1;
            default: return DW'($signed(rng_state[15:0]));
        endcase
    endfunction

    task automatic random_operands();
        for (int k = 0; k < DIM; k++) begin
            weight_in[k] = random_word();
            ifmap_in[k]  = random_word();
        end
    endtask

    // Called on a falling edge, start is sampled on the next rising edge
    task automatic drive_start(input logic mode);
        conv_mode = mode;
        random_operands();
        start = 1'b1;
        runs_planned++;
        @(negedge clk);
        start = 1'b0;
        // Operands matter only at T0, so scramble them
        conv_mode = ~mode;
        random_operands();
    endtask

    task automatic wait_idle();
        int                  cycles;
        mac_pkg::seq_state_t st;
        cycles = 0;
        while (busy && cycles < IDLE_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            st = unified_multiplicator_i.array_sequencer_i.state_q;
            err_count++;
            $display("busy stayed high for %0d cycles, sequencer in %s", cycles, st.name());
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        conv_mode = 1'b0;
        weight_in = '0;
        ifmap_in  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        // Mode 0 then mode 1, one idle cycle between runs
        for (int m = 0; m < 2; m++) begin
            for (int r = 0; r < 16; r++) begin
                @(negedge clk);
                drive_start(1'(m));
                wait_idle();
            end
        end

        // Second start lands while busy and must be dropped
        for (int m = 0; m < 2; m++) begin
            @(negedge clk);
            drive_start(1'(m));
            @(negedge clk);
            start     = 1'b1;
            conv_mode = ~1'(m);
            random_operands();
            @(negedge clk);
            start = 1'b0;
            wait_idle();
        end

        // Back to back, start on the cycle busy drops
        @(negedge clk);
        for (int r = 0; r < 6; r++) begin
            drive_start(1'(r));
            wait_idle();
        end

        repeat (3) @(negedge clk);
        if (runs_started != runs_planned) begin
            err_count++;
            $display("%0d runs were requested but %0d started", runs_planned, runs_started);
        end

        $display("Summary: %0d runs, %0d errors", runs_started, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(CLK_PERIOD * (RESET_CYCLES + RUN_COUNT * RUN_CYCLES));
        $display("Simulation timed out with %0d errors", err_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+.
mac_pkg.sv
pe_ctrl_if.sv
mac_pe.sv
pe_array.sv
array_sequencer.sv
transconv_collect.sv
unified_multiplicator.sv
tb_unified_multiplicator.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
# Status is zero only when the pass message shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module tb_unified_multiplicator \
    -o sim_unified_multiplicator \
    && ./obj_dir/sim_unified_multiplicator \
    | tee /dev/stderr \
    | grep -x '>>> PASS' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

exit 0
